// File: project.f
+incdir+rtl
rtl/adc_delay_pkg.sv
rtl/wb_adc_delay_regs.sv
rtl/adc_delay_lane_bank.sv
rtl/adc_delay_ctrl_top.sv
bench/adc_delay_ctrl_properties.sv
bench/adc_delay_ctrl_tb.sv

// File: Bender.yml
package:
  name: adc_delay_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/adc_delay_pkg.sv
      - rtl/wb_adc_delay_regs.sv
      - rtl/adc_delay_lane_bank.sv
      - rtl/adc_delay_ctrl_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/adc_delay_ctrl_properties.sv
      - bench/adc_delay_ctrl_tb.sv

// File: bench/adc_delay_ctrl_tb.sv
`include "adc_delay_config.svh"

module adc_delay_ctrl_tb
  import adc_delay_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES  = `ADC_DELAY_NUM_LANES;
  localparam int DATA_LANES = NUM_LANES - 1;
  localparam int FRAME_LANE = NUM_LANES - 1;
  localparam int RST_CYCLES = 5;
  localparam int N_LOAD     = 8;
  localparam int N_GATE     = 4;
  localparam int N_OOR      = 4;
  // reset reads, map readback, unmapped words, cleanup, then the tap tests
  localparam int NUM_OPS = 9 + 16 + 15 + 8 + 5 * N_LOAD + 15 * N_GATE + 2 * N_OOR;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  delay_ctrl_t delay_ctrl;
  tap_t        taps [NUM_LANES];

  tap_t        exp_tap [NUM_LANES]; // software view of each lane
  int          err_cnt = 0;
  bit          timed_out = 1'b0;

  adc_delay_ctrl_top i_dut (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .delay_ctrl_o (delay_ctrl),
    .taps_o       (taps)
  );

  bind adc_delay_ctrl_top adc_delay_ctrl_properties i_props (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  // implemented bits of each register word
  function automatic logic [31:0] impl_mask(input logic [3:0] idx);
    case (idx)
      `ADC_DELAY_REG_LOAD_LO, `ADC_DELAY_REG_RST_LO, `ADC_DELAY_REG_VTC_LO: return 32'hffff_ffff;
      `ADC_DELAY_REG_LOAD_HI, `ADC_DELAY_REG_RST_HI, `ADC_DELAY_REG_VTC_HI: return 32'h1;
      `ADC_DELAY_REG_TAP_VAL:  return 32'h1ff;
      `ADC_DELAY_REG_LANE_SEL: return 32'h3f;
      default:                 return 32'h0;
    endcase
  endfunction

  // entered 2 ns after an edge, returns 2 ns after the ack edge
  task automatic bus_op(input logic [3:0] idx, input logic we, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    wb_adr_i = {26'b0, idx, 2'b00};
    wb_dat_i = wdata;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(posedge wb_clk_i);
      #2;
    end while (!wb_ack_o);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
    logic [31:0] unused;
    bus_op(idx, 1'b1, data, unused);
  endtask

  task automatic check_reg(input logic [3:0] idx, input logic [31:0] exp);
    logic [31:0] got;
    bus_op(idx, 1'b0, 32'b0, got);
    if (got !== exp) begin
      $display("** Error at %0d ns: wb_dat_o for reg %0d expected %h, got %h",
               $time, idx, exp, got);
      err_cnt++;
    end
  endtask

  // one lane bit in a LO/HI register pair, all others cleared
  task automatic lane_bit(input logic [3:0] lo_idx, input int lane, input logic val);
    if (lane < DATA_LANES) write_reg(lo_idx, 32'(val) << lane);
    else write_reg(lo_idx + 4'd1, 32'(val));
  endtask

  task automatic check_tap(input int lane, input tap_t exp);
    write_reg(`ADC_DELAY_REG_LANE_SEL, 32'(lane));
    check_reg(`ADC_DELAY_REG_TAP_RD, 32'(exp));
  endtask

  initial begin
    repeat (RST_CYCLES + NUM_OPS * 10) @(posedge wb_clk_i);
    $display("timeout: the bus did not finish all operations in time");
    timed_out = 1'b1;
  end

  initial begin
    wait (err_cnt != 0 || timed_out || i_dut.i_props.fail_cnt != 0);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  end

  initial begin
    int          lane;
    tap_t        val;
    logic [31:0] word;
    void'($urandom(57358));
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = 4'hf;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    foreach (exp_tap[i]) exp_tap[i] = '0;
    repeat (RST_CYCLES) @(posedge wb_clk_i);
    #2 wb_rst_i = 1'b0;

    // reset values, vtc blocks every lane
    for (int i = 0; i <= 8; i++) begin
      word = (i == `ADC_DELAY_REG_VTC_LO || i == `ADC_DELAY_REG_VTC_HI) ? impl_mask(4'(i)) : 0;
      check_reg(4'(i), word);
    end
    for (int i = 0; i < 8; i++) begin
      word = $urandom;
      write_reg(4'(i), word);
      check_reg(4'(i), word & impl_mask(4'(i)));
    end
    write_reg(`ADC_DELAY_REG_TAP_RD, $urandom); // read only, dropped
    for (int i = 9; i < 16; i++) begin
      write_reg(4'(i), $urandom);
      check_reg(4'(i), 32'b0);
    end

    // clear all taps, then open every lane for loads
    write_reg(`ADC_DELAY_REG_RST_LO, 32'hffff_ffff);
    write_reg(`ADC_DELAY_REG_RST_HI, 32'h1);
    write_reg(`ADC_DELAY_REG_LOAD_LO, 32'h0);
    write_reg(`ADC_DELAY_REG_LOAD_HI, 32'h0);
    write_reg(`ADC_DELAY_REG_VTC_LO, 32'h0);
    write_reg(`ADC_DELAY_REG_VTC_HI, 32'h0);
    write_reg(`ADC_DELAY_REG_RST_LO, 32'h0);
    write_reg(`ADC_DELAY_REG_RST_HI, 32'h0);

    for (int n = 0; n < N_LOAD; n++) begin
      lane = (n == 0) ? FRAME_LANE : $urandom_range(NUM_LANES - 1, 0);
      val  = tap_t'($urandom);
      write_reg(`ADC_DELAY_REG_TAP_VAL, 32'(val));
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b1);
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b0);
      exp_tap[lane] = val;
      check_tap(lane, exp_tap[lane]);
    end

    for (int n = 0; n < N_GATE; n++) begin
      lane = (n == 0) ? FRAME_LANE : $urandom_range(NUM_LANES - 1, 0);
      val  = exp_tap[lane] ^ tap_t'($urandom_range(511, 1));
      lane_bit(`ADC_DELAY_REG_VTC_LO, lane, 1'b1);
      write_reg(`ADC_DELAY_REG_TAP_VAL, 32'(val));
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b1);
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b0);
      lane_bit(`ADC_DELAY_REG_VTC_LO, lane, 1'b0);
      check_tap(lane, exp_tap[lane]); // load blocked under vtc
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b1);
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b0);
      lane_bit(`ADC_DELAY_REG_RST_LO, lane, 1'b1);
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b1);
      lane_bit(`ADC_DELAY_REG_LOAD_LO, lane, 1'b0);
      lane_bit(`ADC_DELAY_REG_RST_LO, lane, 1'b0);
      exp_tap[lane] = '0;
      check_tap(lane, exp_tap[lane]);
    end

    for (int n = 0; n < N_OOR; n++) begin
      check_tap($urandom_range(63, NUM_LANES), '0);
    end

    repeat (3) @(posedge wb_clk_i);
    #2;
    if (err_cnt == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: bench/adc_delay_ctrl_properties.sv
`include "adc_delay_config.svh"

module adc_delay_ctrl_properties
  import adc_delay_pkg::*;
(
  input logic        wb_clk_i,
  input logic        wb_rst_i,
  input logic [31:0] wb_adr_i,
  input logic [31:0] wb_dat_i,
  input logic        wb_we_i,
  input logic        wb_cyc_i,
  input logic        wb_stb_i,
  input logic [31:0] wb_dat_o,
  input logic        wb_ack_o,
  input logic        wb_err_o,
  input delay_ctrl_t delay_ctrl_o,
  input tap_t        taps_o [`ADC_DELAY_NUM_LANES]
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0; // watched by the testbench

  logic       wr_req;
  logic [3:0] wr_idx;
  lane_vec_t  masks [3]; // load, rst, en_vtc

  assign wr_req   = wb_cyc_i && wb_stb_i && !wb_ack_o && wb_we_i;
  assign wr_idx   = wb_adr_i[5:2];
  assign masks[0] = delay_ctrl_o.load;
  assign masks[1] = delay_ctrl_o.rst;
  assign masks[2] = delay_ctrl_o.en_vtc;

  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else begin $error("ack held longer than one cycle"); fail_cnt++; end

  a_ack_follows: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
    else begin $error("request not acknowledged on the next edge"); fail_cnt++; end

  a_no_spurious: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (!(wb_cyc_i && wb_stb_i) || wb_ack_o) |=> !wb_ack_o)
    else begin $error("ack raised without a request"); fail_cnt++; end

  a_dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> wb_dat_o == 32'b0)
    else begin $error("read data not zero while ack is low"); fail_cnt++; end

  a_err_low: assert property (@(posedge wb_clk_i) !wb_err_o)
    else begin $error("err raised"); fail_cnt++; end

  a_rst_ctrl: assert property (@(posedge wb_clk_i) wb_rst_i |=>
    (delay_ctrl_o.load == '0 && delay_ctrl_o.rst == '0 &&
     delay_ctrl_o.en_vtc == '1 && delay_ctrl_o.val == '0))
    else begin $error("control outputs wrong after reset"); fail_cnt++; end

  // tap value lands on the ack edge
  a_val_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_o && wb_we_i &&
     wb_adr_i[5:2] == `ADC_DELAY_REG_TAP_VAL)
    |=> delay_ctrl_o.val == $past(wb_dat_i[`ADC_DELAY_TAP_W-1:0]))
    else begin $error("TAP_VAL write not visible on the ack edge"); fail_cnt++; end

  // LO/HI mask pairs, in map order from LOAD_LO
  for (genvar k = 0; k < 3; k++) begin : g_mask
    a_lo_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wr_req && wr_idx == `ADC_DELAY_REG_LOAD_LO + 4'(2 * k))
      |=> masks[k][`ADC_DELAY_NUM_LANES-2:0] == $past(wb_dat_i[`ADC_DELAY_NUM_LANES-2:0]))
      else begin $error("mask word %0d not on the ack edge", 2 * k); fail_cnt++; end

    a_hi_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wr_req && wr_idx == `ADC_DELAY_REG_LOAD_HI + 4'(2 * k))
      |=> masks[k][`ADC_DELAY_NUM_LANES-1] == $past(wb_dat_i[0]))
      else begin $error("mask word %0d not on the ack edge", 2 * k + 1); fail_cnt++; end
  end

  for (genvar i = 0; i < `ADC_DELAY_NUM_LANES; i++) begin : g_lane
    a_tap_init: assert property (@(posedge wb_clk_i) wb_rst_i |=> taps_o[i] == '0)
      else begin $error("lane %0d tap not zero after reset", i); fail_cnt++; end

    a_tap_clear: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      delay_ctrl_o.rst[i] |=> taps_o[i] == '0)
      else begin $error("lane %0d tap not cleared by its reset bit", i); fail_cnt++; end

    a_tap_load: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (!delay_ctrl_o.rst[i] && $rose(delay_ctrl_o.load[i]) && !delay_ctrl_o.en_vtc[i])
      |=> taps_o[i] == $past(delay_ctrl_o.val))
      else begin $error("lane %0d tap did not take the load value", i); fail_cnt++; end

    // no reset and no allowed load edge, tap holds
    a_tap_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (!delay_ctrl_o.rst[i] && !($rose(delay_ctrl_o.load[i]) && !delay_ctrl_o.en_vtc[i]))
      |=> $stable(taps_o[i]))
      else begin $error("lane %0d tap changed without a load edge", i); fail_cnt++; end
  end

endmodule

// File: rtl/adc_delay_ctrl_top.sv
`include "adc_delay_config.svh"

module adc_delay_ctrl_top
  import adc_delay_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,

  output delay_ctrl_t delay_ctrl_o,
  output tap_t        taps_o [`ADC_DELAY_NUM_LANES]
);

  delay_ctrl_t ctrl;
  tap_t        taps [`ADC_DELAY_NUM_LANES];

  wb_adc_delay_regs i_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .taps_i   (taps),
    .ctrl_o   (ctrl)
  );

  adc_delay_lane_bank i_lane_bank (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .ctrl_i   (ctrl),
    .taps_o   (taps)
  );

  // to the delay elements downstream
  assign delay_ctrl_o = ctrl;
  assign taps_o       = taps;

endmodule

// File: rtl/adc_delay_lane_bank.sv
`include "adc_delay_config.svh"

module adc_delay_lane_bank
  import adc_delay_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  delay_ctrl_t ctrl_i,
  output tap_t        taps_o [`ADC_DELAY_NUM_LANES]
);

  lane_vec_t load_q;    // load vector one cycle back
  lane_vec_t load_rise;
  lane_vec_t load_ok;   // rising and not under vtc

  assign load_rise = ctrl_i.load & ~load_q;
  assign load_ok   = load_rise & ~ctrl_i.en_vtc;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_q <= '0;
    end else begin
      load_q <= ctrl_i.load;
    end
  end

  // one tap register per lane
  for (genvar i = 0; i < `ADC_DELAY_NUM_LANES; i++) begin : g_lane
    tap_t tap_q;

    always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
        tap_q <= '0;
      end else if (ctrl_i.rst[i]) begin
        tap_q <= '0; // reset wins over a load edge
      end else if (load_ok[i]) begin
        tap_q <= ctrl_i.val;
      end
    end

    assign taps_o[i] = tap_q;
  end

endmodule

// File: rtl/wb_adc_delay_regs.sv
`include "adc_delay_config.svh"

module wb_adc_delay_regs
  import adc_delay_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i, // full-word writes only
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,

  input  tap_t        taps_i [`ADC_DELAY_NUM_LANES],
  output delay_ctrl_t ctrl_o
);

  localparam int unsigned DATA_LANES = `ADC_DELAY_NUM_LANES - 1;
  localparam int unsigned FRAME_LANE = DATA_LANES;

  logic                  ack_q;
  logic                  req;
  logic [3:0]            reg_idx;
  reg_word_u             wr_word;
  reg_word_u             rd_word;
  logic [31:0]           dat_q;
  delay_ctrl_t           ctrl_q;
  logic [LANE_SEL_W-1:0] lane_sel_q;
  tap_t                  sel_tap;

  // new request only while ack is low
  assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
  assign reg_idx = wb_adr_i[5:2];
  assign wr_word = reg_word_u'(wb_dat_i);

  // tap readback mux, out-of-range select gives zero
  always_comb begin
    sel_tap = '0;
    for (int i = 0; i < `ADC_DELAY_NUM_LANES; i++) begin
      if (lane_sel_q == LANE_SEL_W'(i)) sel_tap = taps_i[i];
    end
  end

  always_comb begin
    rd_word = '0;
    case (reg_idx)
      `ADC_DELAY_REG_LOAD_LO:  rd_word.mask[DATA_LANES-1:0] = ctrl_q.load[DATA_LANES-1:0];
      `ADC_DELAY_REG_LOAD_HI:  rd_word.mask[FRAME_BIT] = ctrl_q.load[FRAME_LANE];
      `ADC_DELAY_REG_RST_LO:   rd_word.mask[DATA_LANES-1:0] = ctrl_q.rst[DATA_LANES-1:0];
      `ADC_DELAY_REG_RST_HI:   rd_word.mask[FRAME_BIT] = ctrl_q.rst[FRAME_LANE];
      `ADC_DELAY_REG_VTC_LO:   rd_word.mask[DATA_LANES-1:0] = ctrl_q.en_vtc[DATA_LANES-1:0];
      `ADC_DELAY_REG_VTC_HI:   rd_word.mask[FRAME_BIT] = ctrl_q.en_vtc[FRAME_LANE];
      `ADC_DELAY_REG_TAP_VAL:  rd_word.tap_w.tap = ctrl_q.val;
      `ADC_DELAY_REG_LANE_SEL: rd_word.mask[LANE_SEL_W-1:0] = lane_sel_q;
      `ADC_DELAY_REG_TAP_RD:   rd_word.tap_w.tap = sel_tap;
      default: ; // unmapped reads zero
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q         <= 1'b0;
      ctrl_q.load   <= '0;
      ctrl_q.rst    <= '0;
      ctrl_q.en_vtc <= '1; // loads blocked until cleared
      ctrl_q.val    <= '0;
      lane_sel_q    <= '0;
    end else begin
      ack_q <= req;
      if (req && wb_we_i) begin
        case (reg_idx)
          `ADC_DELAY_REG_LOAD_LO: begin
            ctrl_q.load[DATA_LANES-1:0] <= wr_word.mask[DATA_LANES-1:0];
          end
          `ADC_DELAY_REG_LOAD_HI: ctrl_q.load[FRAME_LANE] <= wr_word.mask[FRAME_BIT];
          `ADC_DELAY_REG_RST_LO: begin
            ctrl_q.rst[DATA_LANES-1:0] <= wr_word.mask[DATA_LANES-1:0];
          end
          `ADC_DELAY_REG_RST_HI: ctrl_q.rst[FRAME_LANE] <= wr_word.mask[FRAME_BIT];
          `ADC_DELAY_REG_VTC_LO: begin
            ctrl_q.en_vtc[DATA_LANES-1:0] <= wr_word.mask[DATA_LANES-1:0];
          end
          `ADC_DELAY_REG_VTC_HI: ctrl_q.en_vtc[FRAME_LANE] <= wr_word.mask[FRAME_BIT];
          `ADC_DELAY_REG_TAP_VAL: ctrl_q.val <= wr_word.tap_w.tap;
          `ADC_DELAY_REG_LANE_SEL: lane_sel_q <= wr_word.mask[LANE_SEL_W-1:0];
          default: ; // TAP_RD and unmapped writes dropped
        endcase
      end
    end
  end

  // read data, sampled with the request
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      dat_q <= wb_we_i ? 32'b0 : rd_word.mask;
    end
  end

  assign wb_dat_o = ack_q ? dat_q : 32'b0;
  assign wb_ack_o = ack_q;
  assign wb_err_o = 1'b0;
  assign ctrl_o   = ctrl_q;

endmodule

// File: rtl/adc_delay_pkg.sv
`include "adc_delay_config.svh"

package adc_delay_pkg;

  // one bit per delay lane, frame lane is the msb
  typedef logic [`ADC_DELAY_NUM_LANES-1:0] lane_vec_t;

  // tap count of one delay element
  typedef logic [`ADC_DELAY_TAP_W-1:0] tap_t;

  // control bundle, register slave to lane bank
  typedef struct packed {
    lane_vec_t load;   // rising edge loads val
    lane_vec_t rst;    // level, clears tap
    lane_vec_t en_vtc; // high blocks loads
    tap_t      val;    // shared tap value
  } delay_ctrl_t;

  // tap word layout
  typedef struct packed {
    logic [31-`ADC_DELAY_TAP_W:0] pad;
    tap_t                         tap;
  } tap_word_t;

  // one bus word, seen as a lane mask or as a tap word
  typedef union packed {
    logic [31:0] mask;
    tap_word_t   tap_w;
  } reg_word_u;

  // frame lane sits in bit 0 of the _HI words
  localparam int unsigned FRAME_BIT = 0;

  // lane select width, wide enough for out-of-range selects
  localparam int unsigned LANE_SEL_W = 6;

endpackage

// File: rtl/adc_delay_config.svh
`ifndef ADC_DELAY_CONFIG_SVH
`define ADC_DELAY_CONFIG_SVH

// register map below assumes at most 4 units
`define ADC_DELAY_NUM_UNITS 4
`define ADC_DELAY_LANES_PER_UNIT 8
// data lanes plus the frame lane on top
`define ADC_DELAY_NUM_LANES (`ADC_DELAY_NUM_UNITS * `ADC_DELAY_LANES_PER_UNIT + 1)
`define ADC_DELAY_TAP_W 9

// word indices, address bits 5:2
`define ADC_DELAY_REG_LOAD_LO 4'd0
`define ADC_DELAY_REG_LOAD_HI 4'd1
`define ADC_DELAY_REG_RST_LO 4'd2
`define ADC_DELAY_REG_RST_HI 4'd3
`define ADC_DELAY_REG_VTC_LO 4'd4
`define ADC_DELAY_REG_VTC_HI 4'd5
`define ADC_DELAY_REG_TAP_VAL 4'd6
`define ADC_DELAY_REG_LANE_SEL 4'd7
`define ADC_DELAY_REG_TAP_RD 4'd8 // read only

`endif
